//--- hdl/wb_bus_pkg.sv
// Wishbone classic bus description for the cache bus master.
// Fixed 32-bit address and data with 4 byte lanes.
// The address split assumes a 16-byte line of four 32-bit words.
`default_nettype none

package wb_bus_pkg;

    // ==================================================
    // bus widths
    // ==================================================
    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W  = 4;

    // ==================================================
    // address layout
    // ==================================================
    // the split view is the one the burst logic wraps on
    typedef struct packed {
        logic [27:0] line;
        logic [1:0]  word;
        logic [1:0]  byte_off;
    } wb_addr_split_t;

    // one address word read either flat or as line, word and byte
    typedef union packed {
        logic [31:0]    flat;
        wb_addr_split_t split;
    } wb_addr_t;

    // ==================================================
    // byte select patterns
    // ==================================================
    // every read fetches the full word
    localparam logic [WB_SEL_W-1:0] SEL_ALL = 4'b1111;
    localparam logic [WB_SEL_W-1:0] SEL_B0  = 4'b0001;
    localparam logic [WB_SEL_W-1:0] SEL_B1  = 4'b0010;
    localparam logic [WB_SEL_W-1:0] SEL_B2  = 4'b0100;
    localparam logic [WB_SEL_W-1:0] SEL_B3  = 4'b1000;
    localparam logic [WB_SEL_W-1:0] SEL_HI  = 4'b1100;

endpackage

`default_nettype wire

//--- hdl/wb_master_pkg.sv
// Control types of the cache bus master.
// The burst length is tied to the word field of the bus address.
`default_nettype none

package wb_master_pkg;

    // ==================================================
    // sequencer states
    // ==================================================
    // a single transfer goes straight to the last-ack wait
    typedef enum logic [2:0] {
        SEQ_IDLE     = 3'd0,
        SEQ_BURST1   = 3'd1,
        SEQ_BURST2   = 3'd2,
        SEQ_BURST3   = 3'd3,
        SEQ_WAIT_ACK = 3'd4
    } seq_state_t;

    // beats in one quad-word line fill
    localparam int BURST_BEATS = 4;

    // owner of the transfer in flight
    typedef enum logic {
        REQ_ICACHE = 1'b0,
        REQ_DCACHE = 1'b1
    } requester_t;

endpackage

`default_nettype wire

//--- hdl/req_arbiter.sv
// Request arbiter for the instruction and data cache ports.
// Requests are held levels and the data cache always wins.
// Only one transfer is in flight; a new grant waits for done.
// Instruction cache requests are always reads.
`default_nettype none

module req_arbiter
(
    input  wire                                     i_clk,
    input  wire                                     quick_n_reset,
    input  wire                                     i_icache_req,
    input  wire                                     i_icache_qword,
    input  wire [31:0]                              i_icache_address,
    input  wire                                     i_dcache_req,
    input  wire                                     i_dcache_qword,
    input  wire                                     i_dcache_write,
    input  wire [wb_bus_pkg::WB_DATA_W-1:0]         i_dcache_write_data,
    input  wire [wb_bus_pkg::WB_SEL_W-1:0]          i_dcache_byte_enable,
    input  wire [31:0]                              i_dcache_address,
    input  wire                                     i_done,
    output logic                                    o_start,
    output wb_bus_pkg::wb_addr_t                    o_addr,
    output logic                                    o_qword,
    output logic                                    o_write,
    output logic [wb_bus_pkg::WB_DATA_W-1:0]        o_wdata,
    output logic [wb_bus_pkg::WB_SEL_W-1:0]         o_sel,
    output wb_master_pkg::requester_t               o_owner
);

    // low address bits implied by a write byte enable
    function automatic logic [1:0] byte_from_sel(input logic [wb_bus_pkg::WB_SEL_W-1:0] sel);
        logic [1:0] off;
        case (sel)
            wb_bus_pkg::SEL_B0: off = 2'd0;
            wb_bus_pkg::SEL_B1: off = 2'd1;
            wb_bus_pkg::SEL_B2: off = 2'd2;
            wb_bus_pkg::SEL_B3: off = 2'd3;
            wb_bus_pkg::SEL_HI: off = 2'd2;
            default:            off = 2'd0;
        endcase
        return off;
    endfunction

    logic                 busy_r;
    logic                 grant;
    wb_bus_pkg::wb_addr_t dc_addr;
    wb_bus_pkg::wb_addr_t ic_addr;

    // ==================================================
    // grant decision
    // ==================================================
    // the done cycle is skipped so a request being dropped is not taken twice
    assign grant = !busy_r && !o_start && !i_done && (i_dcache_req || i_icache_req);

    // reads are word aligned, writes carry the byte lane in the low bits
    always_comb
    begin
        dc_addr.flat = i_dcache_address;
        dc_addr.split.byte_off = i_dcache_write ? byte_from_sel(i_dcache_byte_enable) : 2'd0;
        ic_addr.flat = i_icache_address;
        ic_addr.split.byte_off = 2'd0;
    end

    // start is a one-cycle pulse, busy covers the rest of the transfer
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            o_start <= 1'b0;
            busy_r  <= 1'b0;
        end
        else
        begin
            o_start <= grant;
            busy_r  <= (busy_r || o_start) && !i_done;
        end
    end

    // ==================================================
    // registered request attributes
    // ==================================================
    always_ff @(posedge i_clk)
    begin
        if (grant)
        begin
            if (i_dcache_req)
            begin
                o_addr  <= dc_addr;
                // a write is never turned into a burst
                o_qword <= i_dcache_qword && !i_dcache_write;
                o_write <= i_dcache_write;
                o_wdata <= i_dcache_write_data;
                o_sel   <= i_dcache_write ? i_dcache_byte_enable : wb_bus_pkg::SEL_ALL;
                o_owner <= wb_master_pkg::REQ_DCACHE;
            end
            else
            begin
                o_addr  <= ic_addr;
                o_qword <= i_icache_qword;
                o_write <= 1'b0;
                o_wdata <= i_dcache_write_data;
                o_sel   <= wb_bus_pkg::SEL_ALL;
                o_owner <= wb_master_pkg::REQ_ICACHE;
            end
        end
    end

    // once busy, no new start may appear until the sequencer reports done
    a_no_start_busy: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (busy_r && !i_done) |=> !o_start);

endmodule

`default_nettype wire

//--- hdl/wb_sequencer.sv
// Wishbone bus sequencer for single transfers and wrapping line bursts.
// A burst is four reads that wrap inside one 16-byte line.
// Only a missing ack stalls; bus outputs hold until it arrives.
// Done pulses on the edge after the final ack.
`default_nettype none

module wb_sequencer
(
    input  wire                                     i_clk,
    input  wire                                     quick_n_reset,
    input  wire                                     i_start,
    input  wb_bus_pkg::wb_addr_t                    i_addr,
    input  wire                                     i_qword,
    input  wire                                     i_write,
    input  wire [wb_bus_pkg::WB_DATA_W-1:0]         i_wdata,
    input  wire [wb_bus_pkg::WB_SEL_W-1:0]          i_sel,
    input  wire                                     i_wb_ack,
    output logic                                    o_done,
    output logic [31:0]                             o_wb_adr,
    output logic [wb_bus_pkg::WB_SEL_W-1:0]         o_wb_sel,
    output logic                                    o_wb_we,
    output logic [wb_bus_pkg::WB_DATA_W-1:0]        o_wb_dat,
    output logic                                    o_wb_cyc,
    output logic                                    o_wb_stb
);

    wb_master_pkg::seq_state_t state_q;
    wb_bus_pkg::wb_addr_t      adr_q;
    logic [1:0]                next_word;
    logic                      in_burst;
    logic                      load;

    assign o_wb_adr = adr_q.flat;
    assign load     = (state_q == wb_master_pkg::SEQ_IDLE) && i_start;
    assign in_burst = state_q inside {wb_master_pkg::SEQ_BURST1,
                                      wb_master_pkg::SEQ_BURST2,
                                      wb_master_pkg::SEQ_BURST3};

    // word index steps through the line and wraps back to word zero
    assign next_word = 2'((adr_q.split.word + 1) % wb_master_pkg::BURST_BEATS);

    // ==================================================
    // control state
    // ==================================================
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state_q  <= wb_master_pkg::SEQ_IDLE;
            o_wb_stb <= 1'b0;
            o_wb_cyc <= 1'b0;
            o_wb_we  <= 1'b0;
            o_done   <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            case (state_q)
                wb_master_pkg::SEQ_IDLE:
                begin
                    if (i_start)
                    begin
                        o_wb_stb <= 1'b1;
                        o_wb_cyc <= 1'b1;
                        o_wb_we  <= i_write;
                        state_q  <= i_qword ? wb_master_pkg::SEQ_BURST1
                                            : wb_master_pkg::SEQ_WAIT_ACK;
                    end
                end
                wb_master_pkg::SEQ_BURST1:
                    if (i_wb_ack)
                        state_q <= wb_master_pkg::SEQ_BURST2;
                wb_master_pkg::SEQ_BURST2:
                    if (i_wb_ack)
                        state_q <= wb_master_pkg::SEQ_BURST3;
                wb_master_pkg::SEQ_BURST3:
                    if (i_wb_ack)
                        state_q <= wb_master_pkg::SEQ_WAIT_ACK;
                wb_master_pkg::SEQ_WAIT_ACK:
                begin
                    // last ack ends the bus cycle and releases the arbiter
                    if (i_wb_ack)
                    begin
                        o_wb_stb <= 1'b0;
                        o_wb_cyc <= 1'b0;
                        o_wb_we  <= 1'b0;
                        o_done   <= 1'b1;
                        state_q  <= wb_master_pkg::SEQ_IDLE;
                    end
                end
                default:
                    state_q <= wb_master_pkg::SEQ_IDLE;
            endcase
        end
    end

    // ==================================================
    // address, select and write data
    // ==================================================
    always_ff @(posedge i_clk)
    begin
        if (load)
        begin
            adr_q.flat <= i_addr.flat;
            o_wb_sel   <= i_sel;
            o_wb_dat   <= i_wdata;
        end
        else if (in_burst && i_wb_ack)
        begin
            adr_q.split.word <= next_word;
        end
    end

    a_stb_cyc: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        o_wb_stb |-> o_wb_cyc);

    // a stalled beat keeps every bus output steady
    a_hold: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr) && $stable(o_wb_sel)
            && $stable(o_wb_we) && $stable(o_wb_dat)));

    a_burst1: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_q == wb_master_pkg::SEQ_BURST1 && i_wb_ack)
            |=> state_q == wb_master_pkg::SEQ_BURST2);
    a_burst2: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_q == wb_master_pkg::SEQ_BURST2 && i_wb_ack)
            |=> state_q == wb_master_pkg::SEQ_BURST3);
    a_burst3: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_q == wb_master_pkg::SEQ_BURST3 && i_wb_ack)
            |=> state_q == wb_master_pkg::SEQ_WAIT_ACK);

endmodule

`default_nettype wire

//--- hdl/reply_router.sv
// Reply router back to the two caches.
// Ready follows the bus ack in the same cycle, one pulse per beat.
// Read data is shared; only the ready tells a cache it is valid.
`default_nettype none

module reply_router
(
    input  wire                                     i_clk,
    input  wire                                     quick_n_reset,
    input  wire                                     i_start,
    input  wb_master_pkg::requester_t               i_owner,
    input  wire                                     i_wb_ack,
    input  wire                                     i_wb_we,
    input  wire [wb_bus_pkg::WB_DATA_W-1:0]         i_wb_dat,
    output logic                                    o_icache_ready,
    output logic [wb_bus_pkg::WB_DATA_W-1:0]        o_icache_read_data,
    output logic                                    o_dcache_ready,
    output logic [wb_bus_pkg::WB_DATA_W-1:0]        o_dcache_read_data
);

    wb_master_pkg::requester_t owner_q;

    // the owner is captured once per transfer, before its first ack
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
            owner_q <= wb_master_pkg::REQ_ICACHE;
        else if (i_start)
            owner_q <= i_owner;
    end

    // ==================================================
    // ack steering
    // ==================================================
    // only the data cache ever writes, so a write ack is always its ready
    assign o_dcache_ready = i_wb_ack && (i_wb_we || owner_q == wb_master_pkg::REQ_DCACHE);
    assign o_icache_ready = i_wb_ack && !i_wb_we && owner_q == wb_master_pkg::REQ_ICACHE;

    assign o_icache_read_data = i_wb_dat;
    assign o_dcache_read_data = i_wb_dat;

    // the arbiter must have handed any write to the data cache
    a_write_owner: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_wb_ack && i_wb_we) |-> (!o_icache_ready && owner_q == wb_master_pkg::REQ_DCACHE));

endmodule

`default_nettype wire

//--- hdl/a25_wb_master.sv
// Wishbone master for the instruction and data caches of a small core.
// Quad-word requests become wrapping four-beat read bursts.
// Writes are single beats with byte enables and ready on their ack.
// Cache requests must be held until ready; ready cannot be stalled.
`default_nettype none

module a25_wb_master
(
    input  wire                                     i_clk,
    input  wire                                     quick_n_reset,

    // instruction cache
    input  wire                                     i_icache_req,
    input  wire                                     i_icache_qword,
    input  wire [31:0]                              i_icache_address,
    output logic [wb_bus_pkg::WB_DATA_W-1:0]        o_icache_read_data,
    output logic                                    o_icache_ready,

    // data cache
    input  wire                                     i_dcache_req,
    input  wire                                     i_dcache_qword,
    input  wire                                     i_dcache_write,
    input  wire [wb_bus_pkg::WB_DATA_W-1:0]         i_dcache_write_data,
    input  wire [wb_bus_pkg::WB_SEL_W-1:0]          i_dcache_byte_enable,
    input  wire [31:0]                              i_dcache_address,
    output logic [wb_bus_pkg::WB_DATA_W-1:0]        o_dcache_read_data,
    output logic                                    o_dcache_ready,

    // wishbone bus
    output logic [31:0]                             o_wb_adr,
    output logic [wb_bus_pkg::WB_SEL_W-1:0]         o_wb_sel,
    output logic                                    o_wb_we,
    input  wire [wb_bus_pkg::WB_DATA_W-1:0]         i_wb_dat,
    output logic [wb_bus_pkg::WB_DATA_W-1:0]        o_wb_dat,
    output logic                                    o_wb_cyc,
    output logic                                    o_wb_stb,
    input  wire                                     i_wb_ack
);

    logic                                   start;
    logic                                   done;
    wb_bus_pkg::wb_addr_t                   addr;
    logic                                   qword;
    logic                                   write;
    logic [wb_bus_pkg::WB_DATA_W-1:0]       wdata;
    logic [wb_bus_pkg::WB_SEL_W-1:0]        sel;
    wb_master_pkg::requester_t              owner;

    // ==================================================
    // input side, bus sequencing, reply side
    // ==================================================
    req_arbiter u_arbiter (
        .i_clk                (i_clk),
        .quick_n_reset        (quick_n_reset),
        .i_icache_req         (i_icache_req),
        .i_icache_qword       (i_icache_qword),
        .i_icache_address     (i_icache_address),
        .i_dcache_req         (i_dcache_req),
        .i_dcache_qword       (i_dcache_qword),
        .i_dcache_write       (i_dcache_write),
        .i_dcache_write_data  (i_dcache_write_data),
        .i_dcache_byte_enable (i_dcache_byte_enable),
        .i_dcache_address     (i_dcache_address),
        .i_done               (done),
        .o_start              (start),
        .o_addr               (addr),
        .o_qword              (qword),
        .o_write              (write),
        .o_wdata              (wdata),
        .o_sel                (sel),
        .o_owner              (owner)
    );

    wb_sequencer u_sequencer (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_start       (start),
        .i_addr        (addr),
        .i_qword       (qword),
        .i_write       (write),
        .i_wdata       (wdata),
        .i_sel         (sel),
        .i_wb_ack      (i_wb_ack),
        .o_done        (done),
        .o_wb_adr      (o_wb_adr),
        .o_wb_sel      (o_wb_sel),
        .o_wb_we       (o_wb_we),
        .o_wb_dat      (o_wb_dat),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb)
    );

    // the router reads the registered write enable back from the bus side
    reply_router u_router (
        .i_clk              (i_clk),
        .quick_n_reset      (quick_n_reset),
        .i_start            (start),
        .i_owner            (owner),
        .i_wb_ack           (i_wb_ack),
        .i_wb_we            (o_wb_we),
        .i_wb_dat           (i_wb_dat),
        .o_icache_ready     (o_icache_ready),
        .o_icache_read_data (o_icache_read_data),
        .o_dcache_ready     (o_dcache_ready),
        .o_dcache_read_data (o_dcache_read_data)
    );

endmodule

`default_nettype wire

//--- tests/tb_a25_wb_master.sv
// Testbench for the cache Wishbone master against a random-wait slave memory.
// Test addresses stay below 0x400 so they fit the 256-word slave memory.
// Requests run one at a time, except the deliberate two-cache collisions.
`default_nettype none

module tb_a25_wb_master;

    localparam int CLK_PERIOD    = 8;
    localparam int N_RAND_SINGLE = 4;
    localparam int N_RAND_QWORD  = 3;
    localparam int N_BE          = 8;
    localparam int N_RANDOM      = 24;
    // fixed reads, qword reads, write and read-back pairs, collisions, random mix
    localparam int N_XFERS = 1 + N_RAND_SINGLE + 2 + 2 * N_RAND_QWORD + 2 * N_BE + 4 + N_RANDOM;
    // four beats of up to three waits plus ack and drop, and the grant overhead
    localparam int XFER_CYCLES = 4 * 5 + 8;

    logic        i_clk = 1'b0;
    logic        quick_n_reset;
    logic        i_icache_req, i_icache_qword;
    logic [31:0] i_icache_address, o_icache_read_data;
    logic        o_icache_ready;
    logic        i_dcache_req, i_dcache_qword, i_dcache_write;
    logic [31:0] i_dcache_write_data, i_dcache_address, o_dcache_read_data;
    logic [3:0]  i_dcache_byte_enable;
    logic        o_dcache_ready;
    logic [31:0] o_wb_adr, i_wb_dat, o_wb_dat;
    logic [3:0]  o_wb_sel;
    logic        o_wb_we, o_wb_cyc, o_wb_stb, i_wb_ack;

    logic [31:0] slave_mem [256];
    logic [31:0] model_mem [256];
    int          wait_left;
    logic        stalled = 1'b0;
    logic [31:0] held_adr;
    logic        beat_dc, beat_we;
    logic [31:0] beat_wdat, beat_rdat;
    logic [3:0]  be_list [N_BE] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                    4'b1100, 4'b0011, 4'b1111, 4'b0110};

    // one entry per expected bus beat, popped on each acknowledge
    logic [31:0] exp_adr[$];
    logic [3:0]  exp_sel[$];
    logic        exp_we[$];
    logic [31:0] exp_wdat[$];
    logic [31:0] exp_rdat[$];
    logic        exp_dc[$];

    a25_wb_master uut (
        .i_clk (i_clk), .quick_n_reset (quick_n_reset),
        .i_icache_req (i_icache_req), .i_icache_qword (i_icache_qword),
        .i_icache_address (i_icache_address), .o_icache_read_data (o_icache_read_data),
        .o_icache_ready (o_icache_ready),
        .i_dcache_req (i_dcache_req), .i_dcache_qword (i_dcache_qword),
        .i_dcache_write (i_dcache_write), .i_dcache_write_data (i_dcache_write_data),
        .i_dcache_byte_enable (i_dcache_byte_enable), .i_dcache_address (i_dcache_address),
        .o_dcache_read_data (o_dcache_read_data), .o_dcache_ready (o_dcache_ready),
        .o_wb_adr (o_wb_adr), .o_wb_sel (o_wb_sel), .o_wb_we (o_wb_we), .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat), .o_wb_cyc (o_wb_cyc), .o_wb_stb (o_wb_stb), .i_wb_ack (i_wb_ack)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // ==================================================
    // reference model
    // ==================================================
    // initial memory contents, mixed from every bit of the byte address
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return ((a ^ 32'h5a3c_96e1) * 32'h0001_0193) + {a[7:0], a[15:8], a[23:16], a[31:24]};
    endfunction

    // bus address of one beat: the word field wraps inside the line,
    // and a write puts the lane of a one-hot enable (or 2 for the upper half) in the low bits
    function automatic logic [31:0] ref_adr(input logic [31:0] adr, input logic write,
                                            input logic [3:0] be, input int beat);
        logic [31:0] r;
        r = {adr[31:4], 2'((int'(adr[3:2]) + beat) % 4), 2'b00};
        if (write && be == 4'b1100)
            r[1:0] = 2'd2;
        for (int b = 0; b < 4; b++)
            if (write && be == (4'b0001 << b))
                r[1:0] = 2'(b);
        return r;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] be);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++)
            if (be[b])
                r[8*b +: 8] = data[8*b +: 8];
        return r;
    endfunction

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // queue the beats a request must produce; writes also update the model memory
    task automatic expect_transfer(input logic dc, input logic [31:0] adr, input logic qword,
                                   input logic write, input logic [31:0] wdata, input logic [3:0] be);
        logic [31:0] a;
        int          beats;
        beats = (qword && !write) ? 4 : 1;
        for (int k = 0; k < beats; k++)
        begin
            a = ref_adr(adr, write, be, k);
            exp_adr.push_back(a);
            exp_sel.push_back(write ? be : 4'b1111);
            exp_we.push_back(write);
            exp_wdat.push_back(wdata);
            exp_rdat.push_back(model_mem[a[9:2]]);
            exp_dc.push_back(dc);
        end
        if (write)
            model_mem[a[9:2]] = merge_bytes(model_mem[a[9:2]], wdata, be);
    endtask

    // ==================================================
    // cache-side drivers
    // ==================================================
    // the request is held until the last ready and dropped on the next edge
    task automatic icache_read(input logic [31:0] adr, input logic qword);
        int seen;
        seen = 0;
        @(posedge i_clk);
        i_icache_req     <= 1'b1;
        i_icache_qword   <= qword;
        i_icache_address <= adr;
        while (seen < (qword ? 4 : 1))
        begin
            @(posedge i_clk);
            if (o_icache_ready)
                seen++;
        end
        i_icache_req <= 1'b0;
    endtask

    task automatic dcache_access(input logic [31:0] adr, input logic qword, input logic write,
                                 input logic [31:0] wdata, input logic [3:0] be);
        int seen;
        seen = 0;
        @(posedge i_clk);
        i_dcache_req         <= 1'b1;
        i_dcache_qword       <= qword;
        i_dcache_write       <= write;
        i_dcache_write_data  <= wdata;
        i_dcache_byte_enable <= be;
        i_dcache_address     <= adr;
        // a qword marking on a write still gives a single beat
        while (seen < ((qword && !write) ? 4 : 1))
        begin
            @(posedge i_clk);
            if (o_dcache_ready)
                seen++;
        end
        i_dcache_req <= 1'b0;
    endtask

    task automatic run_icache(input logic [31:0] adr, input logic qword);
        expect_transfer(1'b0, adr, qword, 1'b0, 32'h0, 4'b1111);
        icache_read(adr, qword);
    endtask

    task automatic run_dcache(input logic [31:0] adr, input logic qword, input logic write,
                              input logic [31:0] wdata, input logic [3:0] be);
        expect_transfer(1'b1, adr, qword, write, wdata, be);
        dcache_access(adr, qword, write, wdata, be);
    endtask

    // ==================================================
    // slave memory with 0 to 3 random wait cycles per beat
    // ==================================================
    always @(posedge i_clk)
    begin
        if (!quick_n_reset || i_wb_ack)
        begin
            i_wb_ack  <= 1'b0;
            wait_left <= $urandom_range(3, 0);
        end
        else if (o_wb_stb)
        begin
            if (wait_left != 0)
                wait_left <= wait_left - 1;
            else
            begin
                i_wb_ack <= 1'b1;
                i_wb_dat <= slave_mem[o_wb_adr[9:2]];
                for (int b = 0; b < 4; b++)
                    if (o_wb_we && o_wb_sel[b])
                        slave_mem[o_wb_adr[9:2]][8*b +: 8] <= o_wb_dat[8*b +: 8];
            end
        end
    end

    // ==================================================
    // compare process, sampled on the rising edge
    // ==================================================
    always @(posedge i_clk)
    begin
        if (quick_n_reset)
        begin
            if (o_wb_stb)
                check_value(o_wb_cyc, 1'b1, "cyc while stb is high");
            // a beat left waiting must keep stb and its address
            if (stalled)
            begin
                check_value(o_wb_stb, 1'b1, "stb while waiting for ack");
                check_value(o_wb_adr, held_adr, "address while waiting for ack");
            end
            check_value(o_icache_ready || o_dcache_ready, i_wb_ack, "ready against ack");
            check_value(o_icache_ready && o_dcache_ready, 1'b0, "both readies at once");
            if (i_wb_ack && exp_adr.size() == 0)
            begin
                $display("The bus acknowledged a beat that no request asked for");
                stop_with_failure();
            end
            else if (i_wb_ack)
            begin
                beat_dc   = exp_dc.pop_front();
                beat_we   = exp_we.pop_front();
                beat_wdat = exp_wdat.pop_front();
                beat_rdat = exp_rdat.pop_front();
                check_value(o_wb_adr, exp_adr.pop_front(), "bus address");
                check_value(o_wb_sel, exp_sel.pop_front(), "bus select");
                check_value(o_wb_we, beat_we, "bus write enable");
                check_value(o_dcache_ready, beat_dc, "data cache ready");
                check_value(o_icache_ready, !beat_dc, "instruction cache ready");
                if (beat_we)
                    check_value(o_wb_dat, beat_wdat, "bus write data");
                else
                    check_value(beat_dc ? o_dcache_read_data : o_icache_read_data,
                                beat_rdat, "read data");
            end
            stalled  <= o_wb_stb && !i_wb_ack;
            held_adr <= o_wb_adr;
        end
    end

    // ends a run that stopped making progress
    initial
    begin
        #((N_XFERS * XFER_CYCLES + 8) * CLK_PERIOD);
        $display("Watchdog expired: the bus master stopped answering before the tests ended");
        stop_with_failure();
    end

    // ==================================================
    // stimulus
    // ==================================================
    initial
    begin
        logic [31:0] adr;
        void'($urandom(32'h899a1bc1));
        quick_n_reset        = 1'b0;
        i_icache_req         = 1'b0;
        i_icache_qword       = 1'b0;
        i_icache_address     = 32'h0;
        i_dcache_req         = 1'b0;
        i_dcache_qword       = 1'b0;
        i_dcache_write       = 1'b0;
        i_dcache_write_data  = 32'h0;
        i_dcache_byte_enable = 4'h0;
        i_dcache_address     = 32'h0;
        i_wb_ack             = 1'b0;
        i_wb_dat             = 32'h0;
        for (int i = 0; i < 256; i++)
        begin
            slave_mem[i] = fill_word(32'(i) << 2);
            model_mem[i] = fill_word(32'(i) << 2);
        end
        repeat (2) @(posedge i_clk);
        quick_n_reset <= 1'b1;
        // values seen at the release edge are the reset values
        check_value(o_wb_stb, 1'b0, "stb after reset");
        check_value(o_wb_cyc, 1'b0, "cyc after reset");
        check_value(o_icache_ready | o_dcache_ready, 1'b0, "ready after reset");

        // single reads: the byte bits of an instruction fetch are cleared
        run_icache(32'h0000_010b, 1'b0);
        for (int n = 0; n < N_RAND_SINGLE; n++)
            run_icache(32'($urandom_range(1023, 0)), 1'b0);

        // wrapping line bursts from both caches
        run_icache(32'h0000_0208, 1'b1);
        run_dcache(32'h0000_030c, 1'b1, 1'b0, 32'h0, 4'b1111);
        for (int n = 0; n < N_RAND_QWORD; n++)
        begin
            run_icache(32'($urandom_range(1023, 0)), 1'b1);
            run_dcache(32'($urandom_range(1023, 0)), 1'b1, 1'b0, 32'h0, 4'b1111);
        end

        // each byte-enable pattern, then a read-back of the same word
        for (int n = 0; n < N_BE; n++)
        begin
            adr = 32'h0000_0180 + 32'(n * 4);
            run_dcache(adr, 1'b0, 1'b1, $urandom, be_list[n]);
            run_dcache(adr, 1'b0, 1'b0, 32'h0, 4'b1111);
        end

        // both caches in the same cycle, the data cache goes first
        expect_transfer(1'b1, 32'h0000_004c, 1'b0, 1'b0, 32'h0, 4'b1111);
        expect_transfer(1'b0, 32'h0000_02a4, 1'b1, 1'b0, 32'h0, 4'b1111);
        fork
            dcache_access(32'h0000_004c, 1'b0, 1'b0, 32'h0, 4'b1111);
            icache_read(32'h0000_02a4, 1'b1);
        join
        expect_transfer(1'b1, 32'h0000_0374, 1'b1, 1'b0, 32'h0, 4'b1111);
        expect_transfer(1'b0, 32'h0000_0090, 1'b0, 1'b0, 32'h0, 4'b1111);
        fork
            dcache_access(32'h0000_0374, 1'b1, 1'b0, 32'h0, 4'b1111);
            icache_read(32'h0000_0090, 1'b0);
        join

        // random mix, including qword markings on writes
        for (int n = 0; n < N_RANDOM; n++)
        begin
            adr = 32'($urandom_range(1023, 0));
            if ($urandom_range(1, 0) == 1)
                run_dcache(adr, 1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)),
                           $urandom, be_list[$urandom_range(N_BE - 1, 0)]);
            else
                run_icache(adr, 1'($urandom_range(1, 0)));
        end

        repeat (4) @(posedge i_clk);
        if (exp_adr.size() == 0)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
        begin
            $display("Some expected bus beats were never acknowledged");
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

//--- project.f
hdl/wb_bus_pkg.sv
hdl/wb_master_pkg.sv
hdl/req_arbiter.sv
hdl/wb_sequencer.sv
hdl/reply_router.sv
hdl/a25_wb_master.sv
tests/tb_a25_wb_master.sv

//--- Bender.yml
package:
  name: a25_wb_master

sources:
  - hdl/wb_bus_pkg.sv
  - hdl/wb_master_pkg.sv
  - hdl/req_arbiter.sv
  - hdl/wb_sequencer.sv
  - hdl/reply_router.sv
  - hdl/a25_wb_master.sv
  - target: test
    files:
      - tests/tb_a25_wb_master.sv
